// ==== logic/board_consts.svh ====
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// RTC divider, clk_10 toggles the output every TERM+1 cycles
`define RTC_DIV_TERM 4
`define RTC_CNT_W 3

// Fan PWM period in clk_10 cycles
`define PWM_PERIOD 16

// Reset generator
`define RST_SYNC_STAGES 2
`define RST_HOLD_CYCLES 8

// Configuration register map
`define CFG_ADDR_CTRL 2'd0
`define CFG_ADDR_BOOT 2'd1
`define CFG_ADDR_FAN 2'd2
`define CFG_ADDR_STATUS 2'd3

`endif

// ==== logic/board_pkg.sv ====
package board_pkg;

  // Boot mode as seen on the board pins
  typedef logic [1:0] boot_mode_t;

  // Fan duty level, high cycles per PWM period
  typedef logic [3:0] fan_level_t;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration port
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [1:0] cfg_addr_t;
  typedef logic [7:0] cfg_data_t;

  // One request beat, write flag on top
  typedef struct packed {
    logic      wr;
    cfg_addr_t addr;
    cfg_data_t wdata;
  } cfg_req_t;

endpackage

// ==== logic/board_ctl_if.sv ====
`timescale 1ns/1ns

interface board_ctl_if;

  logic                  soft_rst_req;
  logic                  fan_ovr_en;
  board_pkg::fan_level_t fan_level;
  logic                  sys_rst_n;

  // Register block, also reports the system reset in STATUS
  modport cfg (
    output soft_rst_req,
    output fan_ovr_en,
    output fan_level,
    input  sys_rst_n
  );

  modport rst (
    input  soft_rst_req,
    output sys_rst_n
  );

  modport fan (
    input  fan_ovr_en,
    input  fan_level,
    input  sys_rst_n
  );

  modport rtc (
    input  sys_rst_n
  );

endinterface

// ==== logic/board_cfg_regs.sv ====
`timescale 1ns/1ns
`include "board_consts.svh"

module board_cfg_regs (
  input  logic                  clk_10,
  input  logic                  rst_n,
  input  board_pkg::boot_mode_t boot_mode_i,
  input  logic                  cfg_req_valid_i,
  input  logic                  cfg_req_write_i,
  input  board_pkg::cfg_addr_t  cfg_req_addr_i,
  input  board_pkg::cfg_data_t  cfg_req_wdata_i,
  output logic                  cfg_req_ready_o,
  output logic                  cfg_rsp_valid_o,
  input  logic                  cfg_rsp_ready_i,
  output board_pkg::cfg_data_t  cfg_rsp_rdata_o,
  output board_pkg::boot_mode_t boot_mode_o,
  board_ctl_if.cfg              ctl
);

  board_pkg::cfg_req_t   req;
  board_pkg::cfg_data_t  rd_data;
  board_pkg::cfg_data_t  rsp_data_q;
  board_pkg::boot_mode_t boot_ovr_q;
  board_pkg::fan_level_t fan_lvl_q;
  logic                  fan_ovr_q;
  logic                  rsp_valid_q;
  logic                  soft_rst_q;
  logic                  req_fire;
  logic                  ctrl_wr;

  assign req = '{wr: cfg_req_write_i, addr: cfg_req_addr_i, wdata: cfg_req_wdata_i};

  // One request in flight, a waiting response blocks the next
  assign cfg_req_ready_o = ~rsp_valid_q;
  assign req_fire        = cfg_req_valid_i & cfg_req_ready_o;
  assign ctrl_wr         = req_fire & req.wr & (req.addr == `CFG_ADDR_CTRL) & req.wdata[0];

  // Board pins merged with the override
  assign boot_mode_o = boot_mode_i | boot_ovr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////////////////////

  // Writes answer with zero, CTRL always reads zero
  always_comb begin
    rd_data = '0;
    if (!req.wr) begin
      case (req.addr)
        `CFG_ADDR_BOOT:   rd_data = {6'b0, boot_ovr_q};
        `CFG_ADDR_FAN:    rd_data = {3'b0, fan_ovr_q, fan_lvl_q};
        `CFG_ADDR_STATUS: rd_data = {5'b0, ctl.sys_rst_n, boot_mode_o};
        default:          rd_data = '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers and response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_10 or negedge rst_n) begin
    if (!rst_n) begin
      boot_ovr_q  <= '0;
      fan_ovr_q   <= 1'b0;
      fan_lvl_q   <= '0;
      soft_rst_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      // Single-cycle pulse toward the reset generator
      soft_rst_q <= ctrl_wr;
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (cfg_rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      if (req_fire && req.wr) begin
        case (req.addr)
          `CFG_ADDR_BOOT: boot_ovr_q <= req.wdata[1:0];
          `CFG_ADDR_FAN: begin
            fan_ovr_q <= req.wdata[4];
            fan_lvl_q <= req.wdata[3:0];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_10) begin
    if (req_fire) begin
      rsp_data_q <= rd_data;
    end
  end

  assign cfg_rsp_valid_o  = rsp_valid_q;
  assign cfg_rsp_rdata_o  = rsp_data_q;
  assign ctl.soft_rst_req = soft_rst_q;
  assign ctl.fan_ovr_en   = fan_ovr_q;
  assign ctl.fan_level    = fan_lvl_q;

  // Response held until the requester takes it
  rsp_hold_a : assert property (@(posedge clk_10) disable iff (!rst_n)
    cfg_rsp_valid_o && !cfg_rsp_ready_i |=> cfg_rsp_valid_o && $stable(cfg_rsp_rdata_o));

endmodule

// ==== logic/board_rst_gen.sv ====
`timescale 1ns/1ns
`include "board_consts.svh"

module board_rst_gen (
  input  logic     clk_10,
  input  logic     rst_n,
  input  logic     testmode_i,
  board_ctl_if.rst ctl,
  output logic     sys_rst_no
);

  localparam int HOLD_W = $clog2(`RST_HOLD_CYCLES + 1);

  logic [HOLD_W-1:0]           hold_cnt_q;
  logic [`RST_SYNC_STAGES-1:0] sync_q;
  logic                        soft_req;
  logic                        hold_active;
  logic                        rst_out;

  // Soft reset only outside test mode
  assign soft_req    = ctl.soft_rst_req & ~testmode_i;
  assign hold_active = soft_req | (hold_cnt_q != '0);

  always_ff @(posedge clk_10 or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt_q <= '0;
    end else if (soft_req) begin
      hold_cnt_q <= HOLD_W'(`RST_HOLD_CYCLES);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // Async assert, release shifts through the chain
  always_ff @(posedge clk_10 or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else if (hold_active) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  // Test mode hands the board reset straight through
  assign rst_out       = testmode_i ? rst_n : sync_q[`RST_SYNC_STAGES-1];
  assign sys_rst_no    = rst_out;
  assign ctl.sys_rst_n = rst_out;

  soft_pulse_a : assert property (@(posedge clk_10) disable iff (!rst_n)
    ctl.soft_rst_req |=> !ctl.soft_rst_req);

endmodule

// ==== logic/rtc_clk_div.sv ====
`timescale 1ns/1ns
`include "board_consts.svh"

module rtc_clk_div (
  input  logic     clk_10,
  board_ctl_if.rtc ctl,
  output logic     rtc_clk_o
);

  logic [`RTC_CNT_W-1:0] cnt_q;
  logic                  rtc_q;
  logic                  wrap;

  assign wrap = (cnt_q == `RTC_CNT_W'(`RTC_DIV_TERM));

  // 10 MHz in, 1 MHz out
  always_ff @(posedge clk_10 or negedge ctl.sys_rst_n) begin
    if (!ctl.sys_rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (wrap) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_clk_o = rtc_q;

  cnt_range_a : assert property (@(posedge clk_10) disable iff (!ctl.sys_rst_n)
    cnt_q <= `RTC_CNT_W'(`RTC_DIV_TERM));

endmodule

// ==== logic/fan_pwm.sv ====
`timescale 1ns/1ns
`include "board_consts.svh"

module fan_pwm (
  input  logic                  clk_10,
  input  board_pkg::fan_level_t fan_sw_i,
  board_ctl_if.fan              ctl,
  output logic                  fan_pwm_o
);

  localparam int CNT_W = $clog2(`PWM_PERIOD);

  logic [CNT_W-1:0]      cnt_q;
  board_pkg::fan_level_t level_sel;
  board_pkg::fan_level_t level_q;
  logic                  period_end;

  // Register override wins over the switches
  assign level_sel  = ctl.fan_ovr_en ? ctl.fan_level : fan_sw_i;
  assign period_end = (cnt_q == CNT_W'(`PWM_PERIOD - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Period counter and level latch
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_10 or negedge ctl.sys_rst_n) begin
    if (!ctl.sys_rst_n) begin
      cnt_q <= '0;
    end else if (period_end) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // New level lands together with the counter wrap
  always_ff @(posedge clk_10 or negedge ctl.sys_rst_n) begin
    if (!ctl.sys_rst_n) begin
      level_q <= '0;
    end else if (period_end) begin
      level_q <= level_sel;
    end
  end

  // High for the first level_q cycles of each period
  assign fan_pwm_o = (cnt_q < level_q);

  level_hold_a : assert property (@(posedge clk_10) disable iff (!ctl.sys_rst_n)
    !$stable(level_q) |-> (cnt_q == '0));

endmodule

// ==== logic/board_glue_top.sv ====
`timescale 1ns/1ns

module board_glue_top (
  input  logic                  clk_10,
  input  logic                  rst_n,
  input  logic                  testmode_i,
  input  board_pkg::boot_mode_t boot_mode_i,
  input  board_pkg::fan_level_t fan_sw_i,

  // Configuration request channel
  input  logic                  cfg_req_valid_i,
  input  logic                  cfg_req_write_i,
  input  board_pkg::cfg_addr_t  cfg_req_addr_i,
  input  board_pkg::cfg_data_t  cfg_req_wdata_i,
  output logic                  cfg_req_ready_o,

  // Configuration response channel
  output logic                  cfg_rsp_valid_o,
  input  logic                  cfg_rsp_ready_i,
  output board_pkg::cfg_data_t  cfg_rsp_rdata_o,

  output board_pkg::boot_mode_t boot_mode_o,
  output logic                  sys_rst_no,
  output logic                  rtc_clk_o,
  output logic                  fan_pwm_o
);

  board_ctl_if u_ctl ();

  ////////////////////////////////////////////////////////////////////////////
  // Configuration registers, on the board reset
  ////////////////////////////////////////////////////////////////////////////

  board_cfg_regs u_cfg_regs (
    .clk_10          (clk_10),
    .rst_n           (rst_n),
    .boot_mode_i     (boot_mode_i),
    .cfg_req_valid_i (cfg_req_valid_i),
    .cfg_req_write_i (cfg_req_write_i),
    .cfg_req_addr_i  (cfg_req_addr_i),
    .cfg_req_wdata_i (cfg_req_wdata_i),
    .cfg_req_ready_o (cfg_req_ready_o),
    .cfg_rsp_valid_o (cfg_rsp_valid_o),
    .cfg_rsp_ready_i (cfg_rsp_ready_i),
    .cfg_rsp_rdata_o (cfg_rsp_rdata_o),
    .boot_mode_o     (boot_mode_o),
    .ctl             (u_ctl)
  );

  ////////////////////////////////////////////////////////////////////////////
  // System reset and the logic it clears
  ////////////////////////////////////////////////////////////////////////////

  board_rst_gen u_rst_gen (
    .clk_10     (clk_10),
    .rst_n      (rst_n),
    .testmode_i (testmode_i),
    .ctl        (u_ctl),
    .sys_rst_no (sys_rst_no)
  );

  rtc_clk_div u_rtc_clk_div (
    .clk_10    (clk_10),
    .ctl       (u_ctl),
    .rtc_clk_o (rtc_clk_o)
  );

  fan_pwm u_fan_pwm (
    .clk_10    (clk_10),
    .fan_sw_i  (fan_sw_i),
    .ctl       (u_ctl),
    .fan_pwm_o (fan_pwm_o)
  );

endmodule

// ==== dv/tb_board_glue.sv ====
`timescale 1ns/1ns
`include "board_consts.svh"

module tb_board_glue;

  // About 500 cycles of tests plus a wide margin
  localparam int MAX_CYCLES = 3000;

  logic                  clk_10;
  logic                  rst_n;
  logic                  testmode_i;
  board_pkg::boot_mode_t boot_mode_i;
  board_pkg::fan_level_t fan_sw_i;
  logic                  cfg_req_valid_i;
  logic                  cfg_req_write_i;
  board_pkg::cfg_addr_t  cfg_req_addr_i;
  board_pkg::cfg_data_t  cfg_req_wdata_i;
  logic                  cfg_req_ready_o;
  logic                  cfg_rsp_valid_o;
  logic                  cfg_rsp_ready_i;
  board_pkg::cfg_data_t  cfg_rsp_rdata_o;
  board_pkg::boot_mode_t boot_mode_o;
  logic                  sys_rst_no;
  logic                  rtc_clk_o;
  logic                  fan_pwm_o;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;

  board_glue_top dut (
    .clk_10          (clk_10),
    .rst_n           (rst_n),
    .testmode_i      (testmode_i),
    .boot_mode_i     (boot_mode_i),
    .fan_sw_i        (fan_sw_i),
    .cfg_req_valid_i (cfg_req_valid_i),
    .cfg_req_write_i (cfg_req_write_i),
    .cfg_req_addr_i  (cfg_req_addr_i),
    .cfg_req_wdata_i (cfg_req_wdata_i),
    .cfg_req_ready_o (cfg_req_ready_o),
    .cfg_rsp_valid_o (cfg_rsp_valid_o),
    .cfg_rsp_ready_i (cfg_rsp_ready_i),
    .cfg_rsp_rdata_o (cfg_rsp_rdata_o),
    .boot_mode_o     (boot_mode_o),
    .sys_rst_no      (sys_rst_no),
    .rtc_clk_o       (rtc_clk_o),
    .fan_pwm_o       (fan_pwm_o)
  );

  // 20 ns clock period
  initial begin
    clk_10 = 1'b0;
    forever #10 clk_10 = ~clk_10;
  end

  always @(posedge clk_10) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, run stopped after %0d cycles with %0d errors", cycles, errors);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // One request and its response with an optional stall before it is taken
  task automatic cfg_access(input string name, input logic wr,
                            input board_pkg::cfg_addr_t addr,
                            input board_pkg::cfg_data_t wdata, input int stall,
                            output board_pkg::cfg_data_t rdata);
    board_pkg::cfg_req_t req;
    req = '{wr: wr, addr: addr, wdata: wdata};
    cfg_req_valid_i = 1'b1;
    cfg_req_write_i = req.wr;
    cfg_req_addr_i  = req.addr;
    cfg_req_wdata_i = req.wdata;
    while (cfg_req_ready_o !== 1'b1) @(negedge clk_10);
    @(negedge clk_10);
    cfg_req_valid_i = 1'b0;
    check_val({name, " rsp valid"}, 8'd1, 8'(cfg_rsp_valid_o));
    rdata = cfg_rsp_rdata_o;
    repeat (stall) begin
      @(negedge clk_10);
      check_val({name, " rsp held"}, 8'd1, 8'(cfg_rsp_valid_o));
      check_val({name, " data held"}, rdata, cfg_rsp_rdata_o);
      check_val({name, " req blocked"}, 8'd0, 8'(cfg_req_ready_o));
    end
    cfg_rsp_ready_i = 1'b1;
    @(negedge clk_10);
    cfg_rsp_ready_i = 1'b0;
    check_val({name, " rsp taken"}, 8'd0, 8'(cfg_rsp_valid_o));
  endtask

  task automatic cfg_write(input string name, input board_pkg::cfg_addr_t addr,
                           input board_pkg::cfg_data_t wdata);
    board_pkg::cfg_data_t rdata;
    cfg_access(name, 1'b1, addr, wdata, 0, rdata);
    check_val({name, " write rsp"}, 8'h00, rdata);
  endtask

  task automatic cfg_read_check(input string name, input board_pkg::cfg_addr_t addr,
                                input board_pkg::cfg_data_t exp, input int stall);
    board_pkg::cfg_data_t rdata;
    cfg_access(name, 1'b0, addr, 8'h00, stall, rdata);
    check_val(name, exp, rdata);
  endtask

  task automatic count_rtc_level(input logic lvl, output int n);
    n = 0;
    while (rtc_clk_o === lvl) begin
      n++;
      @(negedge clk_10);
    end
  endtask

  // Any 16 consecutive cycles of a settled PWM hold exactly L high cycles
  task automatic fan_window(input string name, input board_pkg::fan_level_t exp);
    int n;
    n = 0;
    repeat (2 * `PWM_PERIOD) @(negedge clk_10);
    repeat (`PWM_PERIOD) begin
      @(negedge clk_10);
      if (fan_pwm_o) n++;
    end
    check_val(name, 8'(exp), 8'(n));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_rtc();
    int n;
    check_val("reset req ready", 8'd1, 8'(cfg_req_ready_o));
    check_val("reset rsp valid", 8'd0, 8'(cfg_rsp_valid_o));
    check_val("reset sys rst", 8'd0, 8'(sys_rst_no));
    check_val("reset rtc", 8'd0, 8'(rtc_clk_o));
    check_val("reset fan", 8'd0, 8'(fan_pwm_o));
    rst_n = 1'b1;
    @(negedge clk_10);
    check_val("sync stage 1", 8'd0, 8'(sys_rst_no));
    @(negedge clk_10);
    check_val("sync stage 2", 8'd1, 8'(sys_rst_no));
    while (rtc_clk_o !== 1'b1) @(negedge clk_10);
    count_rtc_level(1'b1, n);
    check_val("rtc high time", 8'd5, 8'(n));
    count_rtc_level(1'b0, n);
    check_val("rtc low time", 8'd5, 8'(n));
  endtask

  task automatic test_regs();
    logic [31:0] rnd;
    repeat (4) begin
      rnd = $random(seed);
      cfg_write("boot write", `CFG_ADDR_BOOT, rnd[7:0]);
      cfg_read_check("boot read", `CFG_ADDR_BOOT, {6'b0, rnd[1:0]}, 0);
      cfg_write("fan write", `CFG_ADDR_FAN, rnd[15:8]);
      cfg_read_check("fan read", `CFG_ADDR_FAN, {3'b0, rnd[12:8]}, 0);
    end
    // Pins still zero, so STATUS shows the override alone
    cfg_read_check("status read", `CFG_ADDR_STATUS, {5'b0, 1'b1, rnd[1:0]}, 5);
    cfg_write("ctrl write", `CFG_ADDR_CTRL, 8'hfe);
    cfg_read_check("ctrl read", `CFG_ADDR_CTRL, 8'h00, 3);
    cfg_write("fan clear", `CFG_ADDR_FAN, 8'h00);
  endtask

  task automatic test_boot_merge();
    logic [31:0]           rnd;
    board_pkg::boot_mode_t pins;
    board_pkg::boot_mode_t ovr;
    repeat (8) begin
      rnd  = $random(seed);
      pins = rnd[1:0];
      ovr  = rnd[3:2];
      cfg_write("boot ovr", `CFG_ADDR_BOOT, {6'b0, ovr});
      boot_mode_i = pins;
      @(negedge clk_10);
      check_val("boot merge", 8'(pins | ovr), 8'(boot_mode_o));
      cfg_read_check("status merge", `CFG_ADDR_STATUS, {5'b0, 1'b1, pins | ovr}, 0);
    end
    boot_mode_i = '0;
  endtask

  task automatic test_fan();
    logic [31:0]           rnd;
    board_pkg::fan_level_t lvl;
    cfg_write("fan ovr off", `CFG_ADDR_FAN, 8'h00);
    fan_sw_i = 4'd0;
    fan_window("fan sw 0", 4'd0);
    fan_sw_i = 4'd7;
    fan_window("fan sw 7", 4'd7);
    fan_sw_i = 4'd15;
    fan_window("fan sw 15", 4'd15);
    rnd      = $random(seed);
    lvl      = rnd[3:0];
    fan_sw_i = ~lvl;
    cfg_write("fan ovr on", `CFG_ADDR_FAN, {3'b0, 1'b1, lvl});
    fan_window("fan override", lvl);
    cfg_write("fan ovr off", `CFG_ADDR_FAN, 8'h00);
    fan_window("fan sw again", ~lvl);
  endtask

  task automatic test_soft_reset();
    logic [31:0]           rnd;
    board_pkg::boot_mode_t boot_val;
    int                    n;
    rnd      = $random(seed);
    boot_val = rnd[1:0] | 2'b01;
    // Full duty, so the PWM is busy when the reset hits
    fan_sw_i = 4'd15;
    cfg_write("boot before reset", `CFG_ADDR_BOOT, {6'b0, boot_val});
    repeat (2 * `PWM_PERIOD) @(negedge clk_10);
    // Returns one cycle after the request is accepted
    cfg_write("ctrl soft reset", `CFG_ADDR_CTRL, 8'h01);
    check_val("soft reset low", 8'd0, 8'(sys_rst_no));
    n = 0;
    while (sys_rst_no !== 1'b1 && n < 20) begin
      check_val("rtc in reset", 8'd0, 8'(rtc_clk_o));
      check_val("fan in reset", 8'd0, 8'(fan_pwm_o));
      n++;
      @(negedge clk_10);
    end
    checks++;
    assert (n > 0 && n + 1 <= 12) else begin
      errors++;
      $display("Soft reset did not release within 12 cycles of acceptance");
    end
    cfg_read_check("boot after reset", `CFG_ADDR_BOOT, {6'b0, boot_val}, 0);

    // Test mode ignores the soft reset
    testmode_i = 1'b1;
    cfg_write("ctrl in testmode", `CFG_ADDR_CTRL, 8'h01);
    check_val("testmode bypass", 8'd1, 8'(sys_rst_no));
    // Pulse already gone, so the synchronizer must still be released
    testmode_i = 1'b0;
    repeat (12) begin
      check_val("testmode no reset", 8'd1, 8'(sys_rst_no));
      @(negedge clk_10);
    end
  endtask

  initial begin
    seed            = 32'hc849ca54;
    rst_n           = 1'b0;
    testmode_i      = 1'b0;
    boot_mode_i     = '0;
    fan_sw_i        = '0;
    cfg_req_valid_i = 1'b0;
    cfg_req_write_i = 1'b0;
    cfg_req_addr_i  = '0;
    cfg_req_wdata_i = '0;
    cfg_rsp_ready_i = 1'b0;
    repeat (4) @(negedge clk_10);

    test_reset_rtc();
    test_regs();
    test_boot_merge();
    test_fan();
    test_soft_reset();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+logic
logic/board_pkg.sv
logic/board_ctl_if.sv
logic/board_cfg_regs.sv
logic/board_rst_gen.sv
logic/rtc_clk_div.sv
logic/fan_pwm.sv
logic/board_glue_top.sv
dv/tb_board_glue.sv

// ==== Makefile ====
# Verilator build for the board glue logic and its testbench

VERILATOR ?= verilator
TOP       ?= tb_board_glue
RTL_TOP   ?= board_glue_top
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass or fail comes from the simulation output itself
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
